//--- common/maze_pkg.sv
package maze_pkg;

    // Playfield geometry
    localparam int GRID_W = 10;
    localparam int GRID_H = 15;
    localparam int CELLS  = GRID_W * GRID_H;

    localparam int H_WALL_BITS = GRID_W * (GRID_H + 1);  // 160
    localparam int V_WALL_BITS = (GRID_W + 1) * GRID_H;  // 165
    localparam int FOOD_BITS   = 2 * CELLS;              // Two bits per cell

    // Food value per kind 0..3
    localparam logic [3:0][7:0] FOOD_COST = {8'd64, 8'd16, 8'd4, 8'd1};

    localparam int START_SCORE = 150;

    // Cadence of step decisions after the painter goes idle
    localparam int STEP_CYCLES = 8;

    // Penalty tick, scaled down for simulation
    localparam int TICK_CYCLES = 256;

    typedef enum logic [1:0] {
        DIR_EAST  = 2'd0,
        DIR_SOUTH = 2'd1,
        DIR_WEST  = 2'd2,
        DIR_NORTH = 2'd3
    } dir_t;

    // One completed step, as seen by scoring and drawing
    typedef struct packed {
        logic [3:0] col;
        logic [3:0] row;
        logic [1:0] food;
    } move_evt_t;

endpackage

//--- common/tft_pkg.sv
package tft_pkg;

    // Panel command opcodes
    localparam logic [7:0] CMD_CASET = 8'h2A;
    localparam logic [7:0] CMD_PASET = 8'h2B;
    localparam logic [7:0] CMD_RAMWR = 8'h2C;

    // Pixels per cell edge
    localparam int CELL_PX = 32;

    localparam logic [15:0] PLAYER_COLOR = 16'hF800;  // RGB565 red

    // dc low selects a command, high selects data
    typedef struct packed {
        logic [7:0] data;
        logic       dc;
    } spi_byte_t;

endpackage

//--- compile.f
+incdir+tests
common/maze_pkg.sv
common/tft_pkg.sv
player/player_mover.sv
player/score_keeper.sv
tft/cell_painter.sv
tft/tft_spi.sv
rtl/hex_display.sv
rtl/maze_game.sv
tests/tb_maze_game.sv

//--- player/player_mover.sv
module player_mover (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [3:0]                       buttons,
    input  logic [maze_pkg::H_WALL_BITS-1:0] h_walls,
    input  logic [maze_pkg::V_WALL_BITS-1:0] v_walls,
    input  logic                             painter_ready,
    input  logic                             game_over,
    input  logic [maze_pkg::FOOD_BITS-1:0]   food,
    output maze_pkg::move_evt_t              evt,
    output logic                             evt_valid
);

    localparam int STEP_W = $clog2(maze_pkg::STEP_CYCLES);

    logic [3:0]        btn_meta;
    logic [3:0]        btn_sync;
    logic [3:0]        pressed;
    logic [3:0]        pos_x;
    logic [3:0]        pos_y;
    maze_pkg::dir_t    dir;
    maze_pkg::dir_t    dir_next;
    logic [STEP_W-1:0] wait_cnt;
    logic              start_pend;
    logic [7:0]        v_idx;
    logic [7:0]        cell_idx;
    logic [3:0]        wall_open;
    logic [3:0]        in_grid;
    logic              step_ok;

    assign pressed = ~btn_sync;  // Buttons are active low

    assign v_idx    = 8'(pos_y) * 8'd11 + 8'(pos_x);  // West edge of current cell
    assign cell_idx = 8'(pos_y) * 8'd10 + 8'(pos_x);  // Also the north edge index

    assign wall_open[0] = ~v_walls[v_idx + 8'd1];
    assign wall_open[1] = ~h_walls[cell_idx + 8'd10];
    assign wall_open[2] = ~v_walls[v_idx];
    assign wall_open[3] = ~h_walls[cell_idx];

    assign in_grid[0] = pos_x < 4'(maze_pkg::GRID_W - 1);
    assign in_grid[1] = pos_y < 4'(maze_pkg::GRID_H - 1);
    assign in_grid[2] = pos_x != 4'd0;
    assign in_grid[3] = pos_y != 4'd0;

    // Lowest numbered pressed button with an open wall wins
    always_comb
    begin
        dir_next = dir;
        for (int i = 3; i >= 0; i--)
        begin
            if (pressed[i] && wall_open[i])
                dir_next = maze_pkg::dir_t'(i);
        end
    end

    assign step_ok = wall_open[dir_next] && in_grid[dir_next];

    assign evt.col  = pos_x;
    assign evt.row  = pos_y;
    assign evt.food = food[{cell_idx, 1'b0} +: 2];

    always_ff @(posedge clk)
    begin
        btn_meta <= buttons;
        btn_sync <= btn_meta;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            pos_x      <= '0;
            pos_y      <= '0;
            dir        <= maze_pkg::DIR_WEST;
            wait_cnt   <= '0;
            start_pend <= 1'b1;
            evt_valid  <= 1'b0;
        end
        else
        begin
            evt_valid <= 1'b0;
            if (start_pend)
            begin
                start_pend <= 1'b0;  // Announce the start cell
                evt_valid  <= 1'b1;
            end
            else if (game_over || !painter_ready || evt_valid)
                wait_cnt <= '0;
            else if (wait_cnt == STEP_W'(maze_pkg::STEP_CYCLES - 1))
            begin
                wait_cnt <= '0;
                dir      <= dir_next;
                if (step_ok)
                begin
                    case (dir_next)
                        maze_pkg::DIR_EAST:  pos_x <= pos_x + 4'd1;
                        maze_pkg::DIR_SOUTH: pos_y <= pos_y + 4'd1;
                        maze_pkg::DIR_WEST:  pos_x <= pos_x - 4'd1;
                        default:             pos_y <= pos_y - 4'd1;
                    endcase
                    evt_valid <= 1'b1;
                end
            end
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    a_pos_in_grid: assert property (@(posedge clk) disable iff (!rst)
        (pos_x < 4'(maze_pkg::GRID_W)) && (pos_y < 4'(maze_pkg::GRID_H)));

endmodule

//--- player/score_keeper.sv
module score_keeper (
    input  logic                clk,
    input  logic                rst,
    input  maze_pkg::move_evt_t evt,
    input  logic                evt_valid,
    output logic [15:0]         score,
    output logic                game_over
);

    localparam int TICK_W = $clog2(maze_pkg::TICK_CYCLES);

    logic [maze_pkg::CELLS-1:0] visited;
    logic [7:0]                 visit_cnt;
    logic [15:0]                gained;
    logic [15:0]                gained_next;
    logic [TICK_W-1:0]          tick_cnt;
    logic [15:0]                seconds;
    logic [7:0]                 cell_idx;
    logic                       first_visit;
    logic [16:0]                total;

    assign cell_idx    = 8'(evt.row) * 8'(maze_pkg::GRID_W) + 8'(evt.col);
    assign first_visit = evt_valid && !visited[cell_idx];

    // Food counts only on the first visit
    assign gained_next = first_visit
                       ? gained + 16'(maze_pkg::FOOD_COST[evt.food])
                       : gained;

    assign total = 17'(maze_pkg::START_SCORE) + 17'(gained_next);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            visited   <= '0;
            visit_cnt <= '0;
            gained    <= '0;
            tick_cnt  <= '0;
            seconds   <= '0;
            score     <= 16'(maze_pkg::START_SCORE);
            game_over <= 1'b0;
        end
        else
        begin
            gained <= gained_next;

            if (tick_cnt == TICK_W'(maze_pkg::TICK_CYCLES - 1))
            begin
                tick_cnt <= '0;
                if (seconds != 16'hFFFF)
                    seconds <= seconds + 16'd1;
            end
            else
                tick_cnt <= tick_cnt + 1'b1;

            // Floored at zero
            score <= (17'(seconds) > total) ? 16'd0 : 16'(total - 17'(seconds));

            if (first_visit)
            begin
                visited[cell_idx] <= 1'b1;
                visit_cnt         <= visit_cnt + 8'd1;
                if (visit_cnt == 8'(maze_pkg::CELLS - 1))
                    game_over <= 1'b1;  // Last unvisited cell reached
            end
        end
    end

    a_game_over_all_visited: assert property (@(posedge clk) disable iff (!rst)
        game_over |-> &visited);

endmodule

//--- rtl/hex_display.sv
module hex_display (
    input  logic [15:0]     score,
    output logic [3:0][6:0] hex_disp
);

    function automatic logic [6:0] seg7(input logic [3:0] nib);
        logic [6:0] on;  // gfedcba, lit = 1
        case (nib)
            4'h0: on = 7'h3F;
            4'h1: on = 7'h06;
            4'h2: on = 7'h5B;
            4'h3: on = 7'h4F;
            4'h4: on = 7'h66;
            4'h5: on = 7'h6D;
            4'h6: on = 7'h7D;
            4'h7: on = 7'h07;
            4'h8: on = 7'h7F;
            4'h9: on = 7'h6F;
            4'hA: on = 7'h77;
            4'hB: on = 7'h7C;
            4'hC: on = 7'h39;
            4'hD: on = 7'h5E;
            4'hE: on = 7'h79;
            default: on = 7'h71;
        endcase
        return ~on;  // Segments are active low
    endfunction

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            hex_disp[i] = seg7(score[4*i +: 4]);
    end

endmodule

//--- rtl/maze_game.sv
module maze_game (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [3:0]                       buttons,
    input  logic [maze_pkg::H_WALL_BITS-1:0] h_walls,
    input  logic [maze_pkg::V_WALL_BITS-1:0] v_walls,
    input  logic [maze_pkg::FOOD_BITS-1:0]   food,
    output logic                             tft_clk,
    output logic                             tft_mosi,
    output logic                             tft_dc,
    output logic                             tft_cs,
    output logic [3:0][6:0]                  hex_disp,
    output logic                             game_over
);

    maze_pkg::move_evt_t evt;
    logic                evt_valid;
    logic                painter_ready;
    tft_pkg::spi_byte_t  spi_byte;
    logic                transmit;
    logic                spi_busy;
    logic [15:0]         score;

    player_mover u_player_mover (
        .clk           (clk),
        .rst           (rst),
        .buttons       (buttons),
        .h_walls       (h_walls),
        .v_walls       (v_walls),
        .painter_ready (painter_ready),
        .game_over     (game_over),
        .food          (food),
        .evt           (evt),
        .evt_valid     (evt_valid)
    );

    score_keeper u_score_keeper (
        .clk       (clk),
        .rst       (rst),
        .evt       (evt),
        .evt_valid (evt_valid),
        .score     (score),
        .game_over (game_over)
    );

    cell_painter u_cell_painter (
        .clk           (clk),
        .rst           (rst),
        .evt           (evt),
        .evt_valid     (evt_valid),
        .spi_busy      (spi_busy),
        .painter_ready (painter_ready),
        .spi_out       (spi_byte),
        .transmit      (transmit)
    );

    tft_spi u_tft_spi (
        .clk      (clk),
        .rst      (rst),
        .spi_in   (spi_byte),
        .transmit (transmit),
        .busy     (spi_busy),
        .tft_clk  (tft_clk),
        .tft_mosi (tft_mosi),
        .tft_dc   (tft_dc),
        .tft_cs   (tft_cs)
    );

    hex_display u_hex_display (
        .score    (score),
        .hex_disp (hex_disp)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the maze game testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_maze_game \
    -o sim_maze_game > build.log 2>&1 || { echo "BUILD FAILED"; exit 1; }
./obj_dir/sim_maze_game > sim.log 2>&1 || true
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

    // Reference model state
    int   gained;
    logic visited[maze_pkg::CELLS];

    function automatic int food_cost(input int kind);
        return 1 << (2 * kind);  // 1, 4, 16, 64
    endfunction

    function automatic int food_kind(input int col, input int row);
        return int'(food[2 * (row * maze_pkg::GRID_W + col) +: 2]);
    endfunction

    function automatic int model_score(input int secs);
        int s;
        s = maze_pkg::START_SCORE + gained - secs;
        return (s < 0) ? 0 : s;
    endfunction

    // Reads the active-low digits back to a number or -1 for an unknown pattern
    function automatic int seg_value(input logic [3:0][6:0] segs);
        int         val;
        int         nib;
        logic [6:0] lit;
        val = 0;
        for (int i = 3; i >= 0; i--)
        begin
            lit = ~segs[i];
            case (lit)
                7'h3F: nib = 0;
                7'h06: nib = 1;
                7'h5B: nib = 2;
                7'h4F: nib = 3;
                7'h66: nib = 4;
                7'h6D: nib = 5;
                7'h7D: nib = 6;
                7'h07: nib = 7;
                7'h7F: nib = 8;
                7'h6F: nib = 9;
                7'h77: nib = 10;
                7'h7C: nib = 11;
                7'h39: nib = 12;
                7'h5E: nib = 13;
                7'h79: nib = 14;
                7'h71: nib = 15;
                default: return -1;
            endcase
            val = val * 16 + nib;
        end
        return val;
    endfunction

    function automatic logic [maze_pkg::FOOD_BITS-1:0] random_food();
        logic [maze_pkg::FOOD_BITS-1:0] f;
        for (int i = 0; i < maze_pkg::FOOD_BITS; i++)
            f[i] = 1'($urandom());
        return f;
    endfunction

    task automatic check_int(input string name, input int got, input int expected);
        checks++;
        assert (got == expected)
        else
        begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic apply_reset(input logic [maze_pkg::H_WALL_BITS-1:0] h,
                               input logic [maze_pkg::V_WALL_BITS-1:0] v,
                               input logic [maze_pkg::FOOD_BITS-1:0] f,
                               input logic [3:0] btn);
        @(negedge clk);
        rst     = 1'b0;
        h_walls = h;
        v_walls = v;
        food    = f;
        buttons = btn;
        repeat (2) @(negedge clk);
        rst    = 1'b1;
        gained = 0;
        for (int i = 0; i < maze_pkg::CELLS; i++)
            visited[i] = 1'b0;
    endtask

    task automatic expect_burst(input int col, input int row);
        int         waited;
        logic [8:0] exp_bytes[9];
        logic [8:0] b;
        waited = 0;
        while (rx_q.size() < 9 && waited < BURST_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (rx_q.size() >= 9)
        else
        begin
            $display("No draw burst for cell (%0d,%0d) arrived in time, t=%0t", col, row, $time);
            errors++;
            return;
        end
        exp_bytes[0] = {tft_pkg::CMD_CASET, 1'b0};
        exp_bytes[1] = {8'((col * 32) >> 8), 1'b1};
        exp_bytes[2] = {8'(col * 32), 1'b1};
        exp_bytes[3] = {tft_pkg::CMD_PASET, 1'b0};
        exp_bytes[4] = {8'((row * 32) >> 8), 1'b1};
        exp_bytes[5] = {8'(row * 32), 1'b1};
        exp_bytes[6] = {tft_pkg::CMD_RAMWR, 1'b0};
        exp_bytes[7] = {8'hF8, 1'b1};
        exp_bytes[8] = {8'h00, 1'b1};
        for (int k = 0; k < 9; k++)
        begin
            b = rx_q.pop_front();
            check_int($sformatf("spi byte %0d {data,dc}", k), int'(b), int'(exp_bytes[k]));
        end
        if (!visited[row * maze_pkg::GRID_W + col])
        begin
            visited[row * maze_pkg::GRID_W + col] = 1'b1;
            gained += food_cost(food_kind(col, row));
        end
    endtask

    task automatic step_to(input logic [3:0] btn, input int col, input int row);
        @(negedge clk);
        buttons = btn;
        expect_burst(col, row);
    endtask

    task automatic check_score();
        int secs;
        int got;
        secs = cyc / maze_pkg::TICK_CYCLES;
        got  = seg_value(hex_disp);
        checks++;
        assert (got == model_score(secs) || got == model_score(secs - 1)
                || got == model_score(secs + 1))
        else
        begin
            $display("FAIL t=%0t hex_disp got %0d expected %0d", $time, got,
                     model_score(secs));
            errors++;
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        check_int("spi bytes while idle", rx_q.size(), 0);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_start_burst();
        int e0;
        e0 = errors;
        apply_reset('0, '0, random_food(), 4'hF);
        expect_burst(0, 0);
        repeat (2) @(negedge clk);
        check_score();
        check_int("game_over", int'(game_over), 0);
        report_test("start_burst", e0);
    endtask

    task automatic test_east_run();
        int e0;
        e0 = errors;
        apply_reset('0, '0, '0, 4'b1110);
        expect_burst(0, 0);
        for (int c = 1; c < maze_pkg::GRID_W; c++)
            expect_burst(c, 0);
        expect_quiet(QUIET_CYCLES);  // Grid edge stops the player
        report_test("east_run", e0);
    endtask

    task automatic test_wall_priority();
        int                             e0;
        logic [maze_pkg::H_WALL_BITS-1:0] h;
        logic [maze_pkg::V_WALL_BITS-1:0] v;
        e0    = errors;
        h     = '0;
        v     = '0;
        v[1]  = 1'b1;  // East of (0,0)
        v[13] = 1'b1;  // East of (1,1)
        h[11] = 1'b1;  // North of (1,1)
        apply_reset(h, v, '0, 4'b1100);
        expect_burst(0, 0);
        expect_burst(0, 1);     // South taken as east is closed
        expect_burst(1, 1);     // East wins over south
        @(negedge clk);
        buttons = 4'b0111;      // Only north pressed and closed
        expect_quiet(QUIET_CYCLES);
        step_to(4'b0101, 1, 2); // South open while north is closed
        report_test("wall_priority", e0);
    endtask

    task automatic test_food_scoring();
        int                             e0;
        logic [maze_pkg::FOOD_BITS-1:0] f;
        e0 = errors;
        f  = random_food();
        for (int c = 0; c < 3; c++)
            f[2 * c] = 1'b1;  // Revisited cells are worth 4 or 64
        apply_reset('0, '0, f, 4'b1110);
        expect_burst(0, 0);
        check_score();
        for (int c = 1; c <= 3; c++)
        begin
            expect_burst(c, 0);
            check_score();
        end
        for (int c = 2; c >= 0; c--)
        begin
            step_to(4'b1011, c, 0);  // Revisits add nothing
            check_score();
        end
        report_test("food_scoring", e0);
    endtask

    task automatic test_penalty_floor();
        int e0;
        e0 = errors;
        apply_reset('1, '1, '0, 4'hF);
        expect_burst(0, 0);
        for (int k = 0; k < 160; k++)
        begin
            repeat (maze_pkg::TICK_CYCLES) @(negedge clk);
            check_score();
        end
        check_int("hex_disp", seg_value(hex_disp), 0);
        check_int("spi bytes while idle", rx_q.size(), 0);
        report_test("penalty_floor", e0);
    endtask

    task automatic test_full_walk();
        int         e0;
        int         col;
        int         row;
        logic [3:0] btn;
        e0  = errors;
        col = 0;
        row = 0;
        apply_reset('0, '0, random_food(), 4'b1110);
        expect_burst(0, 0);
        for (int n = 1; n < maze_pkg::CELLS; n++)
        begin
            if (row % 2 == 0 && col < maze_pkg::GRID_W - 1)
            begin
                btn = 4'b1110;
                col++;
            end
            else if (row % 2 == 1 && col > 0)
            begin
                btn = 4'b1011;
                col--;
            end
            else
            begin
                btn = 4'b1101;
                row++;
            end
            step_to(btn, col, row);
        end
        repeat (3) @(negedge clk);
        check_int("game_over", int'(game_over), 1);
        check_score();
        @(negedge clk);
        buttons = 4'b1011;  // West is open but play has ended
        expect_quiet(QUIET_CYCLES);
        report_test("full_walk", e0);
    endtask

`endif

//--- tests/tb_maze_game.sv
module tb_maze_game;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS        = 10;
    localparam int BURST_TIMEOUT = 1000;  // Cycles allowed for one nine-byte burst
    localparam int QUIET_CYCLES  = 600;

    // Rough length of each test in cycles
    localparam int LEN_START   = 1000;
    localparam int LEN_EAST    = 3000;
    localparam int LEN_WALLS   = 2500;
    localparam int LEN_FOOD    = 2500;
    localparam int LEN_PENALTY = 42000;
    localparam int LEN_WALK    = 32000;
    localparam longint WATCHDOG_NS = 64'(2 * CLK_NS) * 64'(LEN_START + LEN_EAST + LEN_WALLS
                                     + LEN_FOOD + LEN_PENALTY + LEN_WALK);

    logic                             clk;
    logic                             rst;
    logic [3:0]                       buttons;
    logic [maze_pkg::H_WALL_BITS-1:0] h_walls;
    logic [maze_pkg::V_WALL_BITS-1:0] v_walls;
    logic [maze_pkg::FOOD_BITS-1:0]   food;
    logic                             tft_clk;
    logic                             tft_mosi;
    logic                             tft_dc;
    logic                             tft_cs;
    logic [3:0][6:0]                  hex_disp;
    logic                             game_over;

    logic [8:0] rx_q[$];  // {data, dc}
    logic [7:0] rx_sh;
    int         rx_bits;
    int         cyc;
    int         errors;
    int         checks;
    int         tests;

    maze_game u_maze_game (
        .clk       (clk),
        .rst       (rst),
        .buttons   (buttons),
        .h_walls   (h_walls),
        .v_walls   (v_walls),
        .food      (food),
        .tft_clk   (tft_clk),
        .tft_mosi  (tft_mosi),
        .tft_dc    (tft_dc),
        .tft_cs    (tft_cs),
        .hex_disp  (hex_disp),
        .game_over (game_over)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // Cycles since reset release, for the penalty model
    always @(posedge clk)
    begin
        if (!rst)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // SPI monitor
    always @(posedge tft_clk or negedge rst)
    begin
        if (!rst)
        begin
            rx_bits = 0;
            rx_q.delete();
        end
        else if (!tft_cs)
        begin
            rx_sh = {rx_sh[6:0], tft_mosi};
            rx_bits++;
            if (rx_bits == 8)
            begin
                rx_q.push_back({rx_sh, tft_dc});
                rx_bits = 0;
            end
        end
    end

    `include "tb_tasks.svh"

    initial
    begin
        rst     = 1'b0;
        buttons = 4'hF;
        h_walls = '0;
        v_walls = '0;
        food    = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        void'($urandom(32'h991a_2996));

        test_start_burst();
        test_east_run();
        test_wall_priority();
        test_food_scoring();
        test_penalty_floor();
        test_full_walk();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tft/cell_painter.sv
module cell_painter (
    input  logic                clk,
    input  logic                rst,
    input  maze_pkg::move_evt_t evt,
    input  logic                evt_valid,
    input  logic                spi_busy,
    output logic                painter_ready,
    output tft_pkg::spi_byte_t  spi_out,
    output logic                transmit
);

    localparam logic [3:0] LAST_STEP = 4'd8;

    maze_pkg::move_evt_t evt_q;
    logic                active;
    logic [3:0]          step;
    logic [15:0]         x_px;
    logic [15:0]         y_px;
    tft_pkg::spi_byte_t  next_byte;

    assign painter_ready = ~active;

    assign x_px = 16'(evt_q.col) * 16'(tft_pkg::CELL_PX);
    assign y_px = 16'(evt_q.row) * 16'(tft_pkg::CELL_PX);

    // Window setup then one pixel write
    always_comb
    begin
        case (step)
            4'd0:    next_byte = '{data: tft_pkg::CMD_CASET, dc: 1'b0};
            4'd1:    next_byte = '{data: x_px[15:8], dc: 1'b1};
            4'd2:    next_byte = '{data: x_px[7:0], dc: 1'b1};
            4'd3:    next_byte = '{data: tft_pkg::CMD_PASET, dc: 1'b0};
            4'd4:    next_byte = '{data: y_px[15:8], dc: 1'b1};
            4'd5:    next_byte = '{data: y_px[7:0], dc: 1'b1};
            4'd6:    next_byte = '{data: tft_pkg::CMD_RAMWR, dc: 1'b0};
            4'd7:    next_byte = '{data: tft_pkg::PLAYER_COLOR[15:8], dc: 1'b1};
            default: next_byte = '{data: tft_pkg::PLAYER_COLOR[7:0], dc: 1'b1};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            active   <= 1'b0;
            step     <= '0;
            transmit <= 1'b0;
        end
        else if (!active)
        begin
            if (evt_valid)
            begin
                active <= 1'b1;
                step   <= '0;
            end
        end
        else if (transmit)
        begin
            transmit <= 1'b0;  // Serializer has taken the byte
            step     <= step + 4'd1;
        end
        else if (!spi_busy)
        begin
            if (step > LAST_STEP)
                active <= 1'b0;  // Last byte fully shifted out
            else
                transmit <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!active && evt_valid)
            evt_q <= evt;
        if (active && !transmit && !spi_busy)
            spi_out <= next_byte;
    end

    a_no_tx_while_busy: assert property (@(posedge clk) disable iff (!rst)
        transmit |-> !spi_busy);

endmodule

//--- tft/tft_spi.sv
module tft_spi (
    input  logic               clk,
    input  logic               rst,
    input  tft_pkg::spi_byte_t spi_in,
    input  logic               transmit,
    output logic               busy,
    output logic               tft_clk,
    output logic               tft_mosi,
    output logic               tft_dc,
    output logic               tft_cs
);

    logic [7:0] shreg;
    logic [3:0] half_cnt;  // Two clk cycles per bit

    assign tft_mosi = shreg[7];  // MSB first
    assign tft_cs   = ~busy;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            busy     <= 1'b0;
            tft_clk  <= 1'b0;
            tft_dc   <= 1'b0;
            half_cnt <= '0;
        end
        else if (!busy)
        begin
            tft_clk <= 1'b0;
            if (transmit)
            begin
                busy     <= 1'b1;
                tft_dc   <= spi_in.dc;
                half_cnt <= '0;
            end
        end
        else
        begin
            tft_clk  <= ~tft_clk;
            half_cnt <= half_cnt + 4'd1;
            if (half_cnt == 4'd15)
                busy <= 1'b0;
        end
    end

    // Data moves on the falling edge, panel samples on the rising one
    always_ff @(posedge clk)
    begin
        if (!busy && transmit)
            shreg <= spi_in.data;
        else if (busy && tft_clk)
            shreg <= {shreg[6:0], 1'b0};
    end

endmodule
